//--- verilog.f
logic/conv_pkg.sv
logic/bank_ram.sv
logic/load_ctrl.sv
logic/window_seq.sv
logic/mac_array.sv
logic/result_out.sv
logic/conv_layer_top.sv
tests/tb_conv_layer.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_conv_layer -f verilog.f -o tb_sim &&
./obj_dir/tb_sim || exit 1

//--- tests/tb_conv_layer.sv
`timescale 1ns/1ps

module tb_conv_layer;

	localparam int PARA_KERNEL = 2;
	localparam int RUN_A  = 16 * 18 + 10; // 6x6, depth 2, 3x3 kernel
	localparam int RUN_B  = 16 * 4 + 10;  // 5x5, depth 1, 2x2 kernel
	localparam int LOADS  = 72 + 18 + 25 + 4 + 16;
	localparam int BUDGET = 16 + LOADS + 3 * RUN_A + 2 * RUN_B + 120;
	localparam int LIMIT  = 2 * BUDGET;

	logic               clk = 1'b0;
	logic               rst;
	logic               fm_wr_i, wt_wr_i, fm_done_i, wt_done_i, start_i;
	conv_pkg::fm_addr_t fm_addr_i;
	conv_pkg::data_t    fm_data_i;
	conv_pkg::wt_addr_t wt_addr_i;
	conv_pkg::data_t    wt_data_i [PARA_KERNEL];
	conv_pkg::size_t    fm_size_i, fm_depth_i, kernel_size_i;
	logic               fm_ready_o, wt_ready_o, result_valid_o, layer_ready_o;
	conv_pkg::size_t    result_row_o, result_col_o;
	conv_pkg::acc_t     result_o [PARA_KERNEL];

	// what the memories should hold
	conv_pkg::data_t fm_copy [conv_pkg::FM_WORDS];
	conv_pkg::data_t wt_copy [PARA_KERNEL][conv_pkg::WT_WORDS];

	logic [31:0] lcg_state = 32'd46079;
	string       test_name = "reset";
	int          cfg_size, cfg_depth, cfg_ksize;
	int          exp_total = 0;
	int          runs_started = 0;
	int          n_results = 0;
	int          exp_row = 0;
	int          exp_col = 0;
	int          layer_count = 0;
	int          cycles = 0;
	logic        valid_prev = 1'b0; // strobe seen one cycle earlier

	conv_layer_top #(.PARA_KERNEL(PARA_KERNEL)) dut (
		.clk(clk), .rst(rst),
		.fm_wr_i(fm_wr_i), .fm_addr_i(fm_addr_i), .fm_data_i(fm_data_i),
		.wt_wr_i(wt_wr_i), .wt_addr_i(wt_addr_i), .wt_data_i(wt_data_i),
		.fm_done_i(fm_done_i), .wt_done_i(wt_done_i),
		.fm_size_i(fm_size_i), .fm_depth_i(fm_depth_i), .kernel_size_i(kernel_size_i),
		.start_i(start_i), .fm_ready_o(fm_ready_o), .wt_ready_o(wt_ready_o),
		.result_valid_o(result_valid_o), .result_row_o(result_row_o),
		.result_col_o(result_col_o), .result_o(result_o), .layer_ready_o(layer_ready_o)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// valid convolution at one output position for kernel k
	function automatic conv_pkg::acc_t ref_sum(input int k, input int row, input int col);
		conv_pkg::acc_t s;
		conv_pkg::acc_t f;
		conv_pkg::acc_t w;
		s = '0;
		for (int sl = 0; sl < cfg_depth; sl++)
			for (int i = 0; i < cfg_ksize; i++)
				for (int j = 0; j < cfg_ksize; j++) begin
					f = conv_pkg::acc_t'(fm_copy[conv_pkg::fm_address(conv_pkg::size_t'(sl),
						conv_pkg::size_t'(row + i), conv_pkg::size_t'(col + j))]);
					w = conv_pkg::acc_t'(wt_copy[k][conv_pkg::wt_address(conv_pkg::size_t'(sl),
						conv_pkg::size_t'(i), conv_pkg::size_t'(j))]);
					s = s + f * w;
				end
		return s;
	endfunction

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Something failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_acc(input string name, input conv_pkg::acc_t exp_v,
			input conv_pkg::acc_t act_v);
		if (exp_v !== act_v)
			stop_run($sformatf("error %s: expected %0d, actual %0d", name, exp_v, act_v));
	endtask

	task automatic check_pos(input string name, input conv_pkg::size_t exp_v,
			input conv_pkg::size_t act_v);
		if (exp_v !== act_v)
			stop_run($sformatf("error %s: expected %0d, actual %0d", name, exp_v, act_v));
	endtask

	task automatic check_flag(input string name, input logic exp_v, input logic act_v);
		if (exp_v !== act_v)
			stop_run($sformatf("error %s: expected %0b, actual %0b", name, exp_v, act_v));
	endtask

	task automatic draw_value(output conv_pkg::data_t v);
		lcg_state = lcg_next(lcg_state);
		v = conv_pkg::data_t'(int'(lcg_state[23:20]) - 8); // -8 .. 7
	endtask

	task automatic load_fm(input int size, input int depth);
		conv_pkg::data_t    v;
		conv_pkg::fm_addr_t a;
		for (int s = 0; s < depth; s++)
			for (int r = 0; r < size; r++)
				for (int c = 0; c < size; c++) begin
					draw_value(v);
					a = conv_pkg::fm_address(conv_pkg::size_t'(s), conv_pkg::size_t'(r),
						conv_pkg::size_t'(c));
					@(negedge clk);
					fm_wr_i   = 1'b1;
					fm_addr_i = a;
					fm_data_i = v;
					fm_copy[a] = v;
				end
		@(negedge clk);
		fm_wr_i = 1'b0;
	endtask

	task automatic load_wt(input int ks, input int depth);
		conv_pkg::data_t    v;
		conv_pkg::wt_addr_t a;
		for (int s = 0; s < depth; s++)
			for (int i = 0; i < ks; i++)
				for (int j = 0; j < ks; j++) begin
					a = conv_pkg::wt_address(conv_pkg::size_t'(s), conv_pkg::size_t'(i),
						conv_pkg::size_t'(j));
					@(negedge clk);
					wt_wr_i   = 1'b1;
					wt_addr_i = a;
					for (int k = 0; k < PARA_KERNEL; k++) begin
						draw_value(v);
						wt_data_i[k] = v; // own weights per kernel
						wt_copy[k][a] = v;
					end
				end
		@(negedge clk);
		wt_wr_i = 1'b0;
	endtask

	task automatic start_layer(input string name, input int size, input int depth,
			input int ks, input int total);
		@(negedge clk);
		test_name     = name;
		cfg_size      = size;
		cfg_depth     = depth;
		cfg_ksize     = ks;
		fm_size_i     = conv_pkg::size_t'(size);
		fm_depth_i    = conv_pkg::size_t'(depth);
		kernel_size_i = conv_pkg::size_t'(ks);
		exp_total     = total;
		if (total != 0)
			runs_started++;
		start_i = 1'b1;
		@(negedge clk);
		start_i = 1'b0;
	endtask

	task automatic wait_layer();
		while (layer_count < runs_started)
			@(posedge clk);
		repeat (4) @(negedge clk); // room for a second pulse to show up
	endtask

	// these land while busy and must be dropped
	task automatic write_during_run();
		while (n_results == 0)
			@(posedge clk);
		for (int i = 0; i < 4; i++) begin
			@(negedge clk);
			fm_wr_i   = 1'b1;
			fm_addr_i = conv_pkg::fm_address(4'd0, conv_pkg::size_t'(i), conv_pkg::size_t'(i));
			fm_data_i = conv_pkg::data_t'(100 + i);
			wt_wr_i   = 1'b1;
			wt_addr_i = conv_pkg::wt_address(4'd0, 4'd0, conv_pkg::size_t'(i % 2));
			for (int k = 0; k < PARA_KERNEL; k++)
				wt_data_i[k] = conv_pkg::data_t'(-50);
		end
		@(negedge clk);
		fm_wr_i = 1'b0;
		wt_wr_i = 1'b0;
	endtask

	// positions arrive row-major
	always @(negedge clk) begin
		if (rst && result_valid_o) begin
			if (n_results >= exp_total)
				stop_run("a result strobe came without a granted run expecting it");
			else begin
				check_pos({test_name, " row"}, conv_pkg::size_t'(exp_row), result_row_o);
				check_pos({test_name, " col"}, conv_pkg::size_t'(exp_col), result_col_o);
				for (int k = 0; k < PARA_KERNEL; k++)
					check_acc($sformatf("%s kernel %0d", test_name, k),
						ref_sum(k, exp_row, exp_col), result_o[k]);
				n_results++;
				if (exp_col == cfg_size - cfg_ksize) begin
					exp_col = 0;
					exp_row++;
				end else
					exp_col++;
			end
		end
		if (rst && layer_ready_o) begin
			if (layer_count >= runs_started)
				stop_run("layer_ready_o pulsed with no run left to finish");
			else begin
				check_flag({test_name, " layer ready one cycle after last strobe"}, 1'b1,
					valid_prev && n_results == exp_total);
				layer_count++;
				n_results = 0;
				exp_row   = 0;
				exp_col   = 0;
			end
		end
		valid_prev = rst && result_valid_o;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT)
			stop_run("timeout: the test did not finish within the cycle limit");
	end

	initial begin
		rst           = 1'b0;
		fm_wr_i       = 1'b0;
		fm_addr_i     = '0;
		fm_data_i     = '0;
		wt_wr_i       = 1'b0;
		wt_addr_i     = '0;
		for (int k = 0; k < PARA_KERNEL; k++)
			wt_data_i[k] = '0;
		fm_done_i     = 1'b0;
		wt_done_i     = 1'b0;
		fm_size_i     = 4'd6;
		fm_depth_i    = 4'd2;
		kernel_size_i = 4'd3;
		start_i       = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		check_flag("fm ready after reset", 1'b0, fm_ready_o);
		check_flag("wt ready after reset", 1'b0, wt_ready_o);

		load_fm(6, 2);
		load_wt(3, 2);
		fm_done_i = 1'b1; // weights not marked done yet
		start_layer("blocked start", 6, 2, 3, 0);
		repeat (RUN_A) @(negedge clk);
		check_flag("blocked start results", 1'b0, n_results != 0);
		check_flag("blocked start layer pulse", 1'b0, layer_count != 0);
		wt_done_i = 1'b1;
		@(negedge clk);
		check_flag("fm ready after load", 1'b1, fm_ready_o);
		check_flag("wt ready after load", 1'b1, wt_ready_o);

		start_layer("run 6x6 d2 k3", 6, 2, 3, 16);
		wait_layer();

		// fresh data for a smaller layer
		fm_done_i = 1'b0;
		wt_done_i = 1'b0;
		load_fm(5, 1);
		load_wt(2, 1);
		fm_done_i = 1'b1;
		wt_done_i = 1'b1;
		@(negedge clk);
		start_layer("run 5x5 d1 k2", 5, 1, 2, 16);
		write_during_run();
		wait_layer();
		start_layer("rerun 5x5 without reload", 5, 1, 2, 16);
		wait_layer();

		$display("Everything OK");
		$finish;
	end

endmodule

//--- logic/conv_layer_top.sv
`timescale 1ns/1ps

module conv_layer_top #(
	parameter int PARA_KERNEL = conv_pkg::PARA_KERNEL_MAX
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               fm_wr_i,
	input  conv_pkg::fm_addr_t fm_addr_i,
	input  conv_pkg::data_t    fm_data_i,
	input  logic               wt_wr_i,
	input  conv_pkg::wt_addr_t wt_addr_i,
	input  conv_pkg::data_t    wt_data_i [PARA_KERNEL],
	input  logic               fm_done_i,
	input  logic               wt_done_i,
	input  conv_pkg::size_t    fm_size_i,
	input  conv_pkg::size_t    fm_depth_i,
	input  conv_pkg::size_t    kernel_size_i,
	input  logic               start_i,
	output logic               fm_ready_o,
	output logic               wt_ready_o,
	output logic               result_valid_o,
	output conv_pkg::size_t    result_row_o,
	output conv_pkg::size_t    result_col_o,
	output conv_pkg::acc_t     result_o [PARA_KERNEL],
	output logic               layer_ready_o
);

	logic               fm_we, wt_we, go, busy;
	conv_pkg::fm_addr_t fm_waddr, fm_raddr;
	conv_pkg::wt_addr_t wt_waddr, wt_raddr;
	conv_pkg::data_t    fm_wdata, fm_rdata;
	conv_pkg::data_t    wt_wdata [PARA_KERNEL];
	conv_pkg::data_t    wt_rdata [PARA_KERNEL];
	logic               tap_first, tap_last, mac_done;
	conv_pkg::size_t    tap_row, tap_col, mac_row, mac_col;
	conv_pkg::acc_t     mac_sum [PARA_KERNEL];

	load_ctrl #(.PARA_KERNEL(PARA_KERNEL)) u_load_ctrl (
		.clk(clk), .rst(rst),
		.fm_wr_i(fm_wr_i), .fm_addr_i(fm_addr_i), .fm_data_i(fm_data_i),
		.wt_wr_i(wt_wr_i), .wt_addr_i(wt_addr_i), .wt_data_i(wt_data_i),
		.fm_done_i(fm_done_i), .wt_done_i(wt_done_i), .start_i(start_i), .busy_i(busy),
		.fm_we_o(fm_we), .fm_waddr_o(fm_waddr), .fm_wdata_o(fm_wdata),
		.wt_we_o(wt_we), .wt_waddr_o(wt_waddr), .wt_wdata_o(wt_wdata),
		.fm_ready_o(fm_ready_o), .wt_ready_o(wt_ready_o), .go_o(go)
	);

	window_seq u_window_seq (
		.clk(clk), .rst(rst), .go_i(go),
		.fm_size_i(fm_size_i), .fm_depth_i(fm_depth_i), .kernel_size_i(kernel_size_i),
		.fm_raddr_o(fm_raddr), .wt_raddr_o(wt_raddr),
		.tap_first_o(tap_first), .tap_last_o(tap_last),
		.tap_row_o(tap_row), .tap_col_o(tap_col), .busy_o(busy)
	);

	bank_ram #(.word_t(conv_pkg::data_t), .DEPTH(conv_pkg::FM_WORDS)) u_fm_ram (
		.clk(clk), .we_i(fm_we), .waddr_i(fm_waddr), .wdata_i(fm_wdata),
		.raddr_i(fm_raddr), .rdata_o(fm_rdata)
	);

	// one weight bank per parallel kernel
	for (genvar k = 0; k < PARA_KERNEL; k++) begin : g_wt_bank
		bank_ram #(.word_t(conv_pkg::data_t), .DEPTH(conv_pkg::WT_WORDS)) u_wt_ram (
			.clk(clk), .we_i(wt_we), .waddr_i(wt_waddr), .wdata_i(wt_wdata[k]),
			.raddr_i(wt_raddr), .rdata_o(wt_rdata[k])
		);
	end

	mac_array #(.PARA_KERNEL(PARA_KERNEL)) u_mac_array (
		.clk(clk), .rst(rst), .fm_i(fm_rdata), .wt_i(wt_rdata),
		.first_i(tap_first), .last_i(tap_last), .row_i(tap_row), .col_i(tap_col),
		.done_o(mac_done), .sum_o(mac_sum), .row_o(mac_row), .col_o(mac_col)
	);

	result_out #(.PARA_KERNEL(PARA_KERNEL)) u_result_out (
		.clk(clk), .rst(rst), .done_i(mac_done), .sum_i(mac_sum),
		.row_i(mac_row), .col_i(mac_col),
		.fm_size_i(fm_size_i), .kernel_size_i(kernel_size_i),
		.result_valid_o(result_valid_o), .result_row_o(result_row_o),
		.result_col_o(result_col_o), .result_o(result_o), .layer_ready_o(layer_ready_o)
	);

endmodule

//--- logic/result_out.sv
`timescale 1ns/1ps

module result_out #(
	parameter int PARA_KERNEL = conv_pkg::PARA_KERNEL_MAX
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            done_i,
	input  conv_pkg::acc_t  sum_i [PARA_KERNEL],
	input  conv_pkg::size_t row_i,
	input  conv_pkg::size_t col_i,
	input  conv_pkg::size_t fm_size_i,
	input  conv_pkg::size_t kernel_size_i,
	output logic            result_valid_o,
	output conv_pkg::size_t result_row_o,
	output conv_pkg::size_t result_col_o,
	output conv_pkg::acc_t  result_o [PARA_KERNEL],
	output logic            layer_ready_o
);

	conv_pkg::size_t out_last;
	logic            final_pos;
	logic            final_q;

	assign out_last  = fm_size_i - kernel_size_i;
	assign final_pos = done_i && (row_i == out_last) && (col_i == out_last);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			result_valid_o <= 1'b0;
			final_q        <= 1'b0;
			layer_ready_o  <= 1'b0;
		end else begin
			result_valid_o <= done_i;
			final_q        <= final_pos;
			layer_ready_o  <= final_q; // one cycle after the last strobe
		end
	end

	always_ff @(posedge clk) begin
		if (done_i) begin
			result_o     <= sum_i;
			result_row_o <= row_i;
			result_col_o <= col_i;
		end
	end

endmodule

//--- logic/mac_array.sv
`timescale 1ns/1ps

module mac_array #(
	parameter int PARA_KERNEL = conv_pkg::PARA_KERNEL_MAX
) (
	input  logic            clk,
	input  logic            rst,
	input  conv_pkg::data_t fm_i,
	input  conv_pkg::data_t wt_i [PARA_KERNEL],
	input  logic            first_i,
	input  logic            last_i,
	input  conv_pkg::size_t row_i,
	input  conv_pkg::size_t col_i,
	output logic            done_o,
	output conv_pkg::acc_t  sum_o [PARA_KERNEL],
	output conv_pkg::size_t row_o,
	output conv_pkg::size_t col_o
);

	logic signed [2*conv_pkg::DATA_W-1:0] prod [PARA_KERNEL];
	conv_pkg::acc_t acc     [PARA_KERNEL];
	conv_pkg::acc_t acc_nxt [PARA_KERNEL];
	logic           tap_open; // between first and last of one position

	always_comb begin
		for (int k = 0; k < PARA_KERNEL; k++) begin
			prod[k]    = fm_i * wt_i[k]; // one feature value feeds every kernel
			acc_nxt[k] = first_i ? prod[k] : acc[k] + prod[k];
		end
	end

	always_ff @(posedge clk) begin
		acc <= acc_nxt;
		if (last_i) begin
			sum_o <= acc_nxt; // next position may load acc right away
			row_o <= row_i;
			col_o <= col_i;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			done_o   <= 1'b0;
			tap_open <= 1'b0;
		end else begin
			done_o <= last_i;
			if (last_i)
				tap_open <= 1'b0;
			else if (first_i)
				tap_open <= 1'b1;
		end
	end

	a_last_after_first: assert property (@(posedge clk) disable iff (!rst)
		last_i |-> (tap_open || first_i));

endmodule

//--- logic/window_seq.sv
`timescale 1ns/1ps

module window_seq (
	input  logic               clk,
	input  logic               rst,
	input  logic               go_i,
	input  conv_pkg::size_t    fm_size_i,
	input  conv_pkg::size_t    fm_depth_i,
	input  conv_pkg::size_t    kernel_size_i,
	output conv_pkg::fm_addr_t fm_raddr_o,
	output conv_pkg::wt_addr_t wt_raddr_o,
	output logic               tap_first_o,
	output logic               tap_last_o,
	output conv_pkg::size_t    tap_row_o,
	output conv_pkg::size_t    tap_col_o,
	output logic               busy_o
);

	// tag, mac and result stages still in flight after the last read
	localparam logic [2:0] DRAIN = 3'd4;

	logic            run;
	logic [2:0]      drain;
	conv_pkg::size_t orow, ocol, sl, kr, kc;
	conv_pkg::size_t out_last;
	logic            kc_end, kr_end, sl_end, oc_end, or_end;
	logic            first_now, last_now;

	// first tag stage lines up with the address register
	logic            first_q, last_q;
	conv_pkg::size_t row_q, col_q;

	assign out_last  = fm_size_i - kernel_size_i; // last output index
	assign kc_end    = (kc == kernel_size_i - 4'd1);
	assign kr_end    = (kr == kernel_size_i - 4'd1);
	assign sl_end    = (sl == fm_depth_i - 4'd1);
	assign oc_end    = (ocol == out_last);
	assign or_end    = (orow == out_last);
	assign first_now = (sl == 4'd0) && (kr == 4'd0) && (kc == 4'd0);
	assign last_now  = kc_end && kr_end && sl_end;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			run    <= 1'b0;
			busy_o <= 1'b0;
			drain  <= '0;
			orow   <= '0;
			ocol   <= '0;
			sl     <= '0;
			kr     <= '0;
			kc     <= '0;
		end else if (go_i) begin
			run    <= 1'b1;
			busy_o <= 1'b1;
			drain  <= '0;
			orow   <= '0;
			ocol   <= '0;
			sl     <= '0;
			kr     <= '0;
			kc     <= '0;
		end else if (run) begin
			kc <= kc_end ? 4'd0 : kc + 4'd1;
			if (kc_end) begin
				kr <= kr_end ? 4'd0 : kr + 4'd1;
				if (kr_end) begin
					sl <= sl_end ? 4'd0 : sl + 4'd1;
					if (sl_end) begin // position complete
						ocol <= oc_end ? 4'd0 : ocol + 4'd1;
						if (oc_end) begin
							orow <= orow + 4'd1;
							if (or_end) begin
								run   <= 1'b0;
								drain <= DRAIN;
							end
						end
					end
				end
			end
		end else if (drain != '0) begin
			drain <= drain - 3'd1;
			if (drain == 3'd1)
				busy_o <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			first_q     <= 1'b0;
			last_q      <= 1'b0;
			tap_first_o <= 1'b0;
			tap_last_o  <= 1'b0;
		end else begin
			first_q     <= run & first_now;
			last_q      <= run & last_now;
			tap_first_o <= first_q; // aligned with ram data
			tap_last_o  <= last_q;
		end
	end

	always_ff @(posedge clk) begin
		fm_raddr_o <= conv_pkg::fm_address(sl, orow + kr, ocol + kc);
		wt_raddr_o <= conv_pkg::wt_address(sl, kr, kc);
		row_q      <= orow;
		col_q      <= ocol;
		tap_row_o  <= row_q;
		tap_col_o  <= col_q;
	end

	a_kernel_fits: assert property (@(posedge clk) disable iff (!rst)
		go_i |-> (kernel_size_i <= fm_size_i));

endmodule

//--- logic/load_ctrl.sv
`timescale 1ns/1ps

module load_ctrl #(
	parameter int PARA_KERNEL = conv_pkg::PARA_KERNEL_MAX
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               fm_wr_i,
	input  conv_pkg::fm_addr_t fm_addr_i,
	input  conv_pkg::data_t    fm_data_i,
	input  logic               wt_wr_i,
	input  conv_pkg::wt_addr_t wt_addr_i,
	input  conv_pkg::data_t    wt_data_i [PARA_KERNEL],
	input  logic               fm_done_i,
	input  logic               wt_done_i,
	input  logic               start_i,
	input  logic               busy_i,
	output logic               fm_we_o,
	output conv_pkg::fm_addr_t fm_waddr_o,
	output conv_pkg::data_t    fm_wdata_o,
	output logic               wt_we_o,
	output conv_pkg::wt_addr_t wt_waddr_o,
	output conv_pkg::data_t    wt_wdata_o [PARA_KERNEL],
	output logic               fm_ready_o,
	output logic               wt_ready_o,
	output logic               go_o
);

	// go counts as busy too since busy only rises a cycle after it
	logic lock;
	assign lock = busy_i | go_o;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			fm_we_o    <= 1'b0;
			wt_we_o    <= 1'b0;
			fm_ready_o <= 1'b0;
			wt_ready_o <= 1'b0;
			go_o       <= 1'b0;
		end else begin
			fm_we_o    <= fm_wr_i & ~lock; // dropped during a run
			wt_we_o    <= wt_wr_i & ~lock;
			fm_ready_o <= fm_done_i;
			wt_ready_o <= wt_done_i;
			go_o       <= start_i & fm_ready_o & wt_ready_o & ~lock;
		end
	end

	always_ff @(posedge clk) begin
		fm_waddr_o <= fm_addr_i;
		fm_wdata_o <= fm_data_i;
		wt_waddr_o <= wt_addr_i;
		wt_wdata_o <= wt_data_i; // same address in every bank
	end

	a_go_idle: assert property (@(posedge clk) disable iff (!rst) go_o |-> !busy_i);

endmodule

//--- logic/bank_ram.sv
`timescale 1ns/1ps

module bank_ram #(
	parameter type word_t = logic [15:0],
	parameter int  DEPTH  = 16
) (
	input  logic                     clk,
	input  logic                     we_i,
	input  logic [$clog2(DEPTH)-1:0] waddr_i,
	input  word_t                    wdata_i,
	input  logic [$clog2(DEPTH)-1:0] raddr_i,
	output word_t                    rdata_o
);

	word_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
	end

	// read data lands one cycle after the address
	always_ff @(posedge clk) begin
		rdata_o <= mem[raddr_i];
	end

	// load side must stay inside the array
	a_waddr_range: assert property (@(posedge clk) we_i |-> (waddr_i < DEPTH));

endmodule

//--- logic/conv_pkg.sv
package conv_pkg;

	localparam int DATA_W          = 16;
	localparam int ACC_W           = 40;
	localparam int FM_SIZE_MAX     = 8;
	localparam int DEPTH_MAX       = 4;
	localparam int KERNEL_SIZE_MAX = 3;
	localparam int PARA_KERNEL_MAX = 2; // default kernel parallelism

	// memory sizes in words
	localparam int FM_WORDS = DEPTH_MAX * FM_SIZE_MAX * FM_SIZE_MAX;
	localparam int WT_WORDS = DEPTH_MAX * KERNEL_SIZE_MAX * KERNEL_SIZE_MAX;

	typedef logic signed [DATA_W-1:0]        data_t;
	typedef logic signed [ACC_W-1:0]         acc_t;
	typedef logic [$clog2(FM_WORDS)-1:0]     fm_addr_t;
	typedef logic [$clog2(WT_WORDS)-1:0]     wt_addr_t;
	typedef logic [3:0]                      size_t;

	// slice-major, then row, then column
	function automatic fm_addr_t fm_address(size_t slice, size_t row, size_t col);
		return fm_addr_t'((slice * FM_SIZE_MAX + row) * FM_SIZE_MAX + col);
	endfunction

	function automatic wt_addr_t wt_address(size_t slice, size_t row, size_t col);
		return wt_addr_t'((slice * KERNEL_SIZE_MAX + row) * KERNEL_SIZE_MAX + col);
	endfunction

endpackage
